//--- Makefile
# Verilator build and run of the z180 glue testbench
TOP := z180_glue_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, scan $(LOG) for failure"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -f z180_glue_top.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TESTBENCH FAILED" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation run failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- rtl/boot_rom.hex
// boot image for the shadow rom, hex bytes loaded from address 000
// columns: the code bytes of one z180 instruction, then its mnemonic
@000
f3          // di
31 00 00    // ld sp,0000  stack grows down from the top of sram
3e 04       // ld a,04  sd card deselected, sck and mosi low
d3 f1       // out (f1),a
db f0       // in a,(f0)  bit 7 miso, bit 6 card detect
e6 40       // and 40
28 fa       // jr z,0008  spin until a card is seen
db fe       // in a,(fe)  boot rom off, low memory is sram now
c3 00 10    // jp 1000  fetched from sram, the loader left a copy here
76          // halt, never reached
@0ff
a5          // marker byte at the top of the image

//--- rtl/boot_rom.sv
//**************************************
// boot rom, registered read
// image from rtl/boot_rom.hex, unlisted bytes read ff
//**************************************
`timescale 1ns/100ps

module boot_rom #(
    parameter int ROM_ADDR_BITS = 12      // 2**ROM_ADDR_BITS bytes
) (
    input  logic                     hwclk,
    input  logic [ROM_ADDR_BITS-1:0] addr,
    output z180_glue_pkg::byte_t     data  // valid one clock after addr
);
    import z180_glue_pkg::*;

    localparam int    ROM_DEPTH = 2 ** ROM_ADDR_BITS;
    localparam string ROM_FILE  = "rtl/boot_rom.hex";

    byte_t mem [ROM_DEPTH];

    //**************************************
    // image load
    //**************************************

    initial begin
        for (int i = 0; i < ROM_DEPTH; i++) begin
            mem[i] = 8'hff;                    // erased value
        end
        $readmemh(ROM_FILE, mem);
    end

    //**************************************
    // read port
    //**************************************

    always_ff @(posedge hwclk) begin
        data <= mem[addr];                     // inferred block rom
    end

endmodule

//--- rtl/bus_cycle_sync.sv
//**************************************
// cpu strobes, address and data brought into hwclk
// strobes must last >= 6 hwclk, bus stable while strobed
//**************************************
`timescale 1ns/100ps

module bus_cycle_sync (
    input  logic                      hwclk,
    input  logic                      reset_n,
    input  z180_glue_pkg::addr_t      a,
    input  z180_glue_pkg::byte_t      d_in,
    input  logic                      rd_n,
    input  logic                      wr_n,
    input  logic                      mreq_n,
    input  logic                      iorq_n,
    input  logic                      m1_n,
    output z180_glue_pkg::bus_cycle_e cycle,
    output z180_glue_pkg::addr_t      addr_s,
    output z180_glue_pkg::byte_t      data_s,
    output logic                      cycle_start,  // first clock of a cycle
    output logic                      cycle_end     // first idle clock after a cycle
);
    import z180_glue_pkg::*;

    logic [4:0] strb_sync [SYNC_STAGES];  // {m1, iorq, mreq, wr, rd} active low
    addr_t      a_sync    [SYNC_STAGES];
    byte_t      d_sync    [SYNC_STAGES];
    logic       rd_s, wr_s, mreq_s, iorq_s, m1_s;  // synced, active high
    bus_cycle_e cycle_nxt;

    //**************************************
    // synchronizer chains
    //**************************************

    always_ff @(posedge hwclk) begin
        if (!reset_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                strb_sync[i] <= '1;               // all strobes released
            end
        end else begin
            strb_sync[0] <= {m1_n, iorq_n, mreq_n, wr_n, rd_n};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                strb_sync[i] <= strb_sync[i-1];
            end
        end
    end

    // address and data get one extra stage to line up with cycle
    always_ff @(posedge hwclk) begin
        a_sync[0] <= a;
        d_sync[0] <= d_in;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            a_sync[i] <= a_sync[i-1];
            d_sync[i] <= d_sync[i-1];
        end
        addr_s <= a_sync[SYNC_STAGES-1];
        data_s <= d_sync[SYNC_STAGES-1];
    end

    assign {m1_s, iorq_s, mreq_s, wr_s, rd_s} = ~strb_sync[SYNC_STAGES-1];

    //**************************************
    // cycle classifier
    //**************************************

    always_comb begin
        cycle_nxt = cycle;
        if (cycle == CYC_IDLE) begin
            if (mreq_s && rd_s)              cycle_nxt = CYC_MEM_RD;
            else if (mreq_s && wr_s)         cycle_nxt = CYC_MEM_WR;
            else if (iorq_s && !m1_s && rd_s) cycle_nxt = CYC_IO_RD;  // m1 low = int ack
            else if (iorq_s && !m1_s && wr_s) cycle_nxt = CYC_IO_WR;
        end else if (!(rd_s || wr_s || mreq_s || iorq_s)) begin
            cycle_nxt = CYC_IDLE;            // leave only once every strobe is gone
        end
    end

    always_ff @(posedge hwclk) begin
        if (!reset_n) begin
            cycle       <= CYC_IDLE;
            cycle_start <= 1'b0;
            cycle_end   <= 1'b0;
        end else begin
            cycle       <= cycle_nxt;
            cycle_start <= (cycle == CYC_IDLE) && (cycle_nxt != CYC_IDLE);
            cycle_end   <= (cycle != CYC_IDLE) && (cycle_nxt == CYC_IDLE);
        end
    end

endmodule

//--- rtl/data_bus_driver.sv
//**************************************
// data bus drive and sram enables
// outputs lag cycle by one clock
// d_out is don't-care while d_oe is low
//**************************************
`timescale 1ns/100ps

module data_bus_driver #(
    parameter int                   ROM_ADDR_BITS = 12,
    parameter z180_glue_pkg::addr_t RAM_START     = 20'h0_1000  // first unshadowed address
) (
    input  logic                      hwclk,
    input  logic                      reset_n,
    input  z180_glue_pkg::bus_cycle_e cycle,
    input  z180_glue_pkg::addr_t      addr_s,
    input  logic                      rom_shadow,
    input  logic                      gpio_rd_sel,
    input  logic                      sd_miso,
    input  logic                      sd_det,
    output z180_glue_pkg::byte_t      d_out,
    output logic                      d_oe,     // board top enables the pad driver
    output logic                      ce_n,     // sram chip enable
    output logic                      oe_n,     // sram output enable
    output logic                      we_n      // sram write enable
);
    import z180_glue_pkg::*;

    byte_t rom_data;      // rom byte, registered inside boot_rom
    byte_t gpio_data;     // sampled sd inputs
    logic  rom_hit;       // this read is served by the rom
    logic  mem_cyc;
    logic  sel_rom;       // drive rom_data, else gpio_data

    boot_rom #(
        .ROM_ADDR_BITS (ROM_ADDR_BITS)
    ) u_boot_rom (
        .hwclk (hwclk),
        .addr  (addr_s[ROM_ADDR_BITS-1:0]),
        .data  (rom_data)
    );

    assign rom_hit = rom_shadow && (cycle == CYC_MEM_RD) && (addr_s < RAM_START);
    assign mem_cyc = (cycle == CYC_MEM_RD) || (cycle == CYC_MEM_WR);

    //**************************************
    // registered drive and enables
    //**************************************

    always_ff @(posedge hwclk) begin
        if (!reset_n) begin
            d_oe    <= 1'b0;
            sel_rom <= 1'b0;
            ce_n    <= 1'b1;
            oe_n    <= 1'b1;
            we_n    <= 1'b1;
        end else begin
            d_oe    <= rom_hit || gpio_rd_sel;
            sel_rom <= rom_hit;
            ce_n    <= !(mem_cyc && !rom_hit);     // sram idle while the rom answers
            oe_n    <= !(cycle == CYC_MEM_RD);
            we_n    <= !(cycle == CYC_MEM_WR);
        end
    end

    always_ff @(posedge hwclk) begin
        gpio_data <= {sd_miso, sd_det, 6'b0};      // miso bit 7, detect bit 6
    end

    assign d_out = sel_rom ? rom_data : gpio_data;

endmodule

//--- rtl/io_port_regs.sv
//**************************************
// i/o decode for ports f0, f1 and fe
// only a[7:0] is compared, upper address bits ignored
// rom shadow comes back only through reset
//**************************************
`timescale 1ns/100ps

module io_port_regs (
    input  logic                      hwclk,
    input  logic                      reset_n,
    input  z180_glue_pkg::bus_cycle_e cycle,
    input  z180_glue_pkg::addr_t      addr_s,
    input  z180_glue_pkg::byte_t      data_s,
    input  logic                      cycle_start,
    input  logic                      cycle_end,
    output logic                      rom_shadow,   // 1 = boot rom overlays low memory
    output logic                      gpio_rd_sel,  // port f0 read in progress
    output z180_glue_pkg::byte_t      gpio_out      // sd pin latch
);
    import z180_glue_pkg::*;

    io_port_t port;          // port number of the current cycle
    logic     io_rd;         // i/o read cycle active
    logic     io_wr;         // i/o write cycle active
    logic     hit_gpio_in;
    logic     hit_gpio_out;
    logic     hit_rom_off;
    logic     wr_f1_pend;    // an f1 write is under way
    byte_t    wr_data;       // last data byte seen during the f1 write

    //**************************************
    // port decode
    //**************************************

    assign port  = io_port_t'(addr_s[7:0]);
    assign io_rd = (cycle == CYC_IO_RD);
    assign io_wr = (cycle == CYC_IO_WR);

    assign hit_gpio_in  = io_rd && (port == PORT_GPIO_IN);
    assign hit_gpio_out = io_wr && (port == PORT_GPIO_OUT);
    assign hit_rom_off  = io_rd && (port == PORT_ROM_OFF);

    // level for the whole read, the bus driver registers it
    assign gpio_rd_sel = hit_gpio_in;

    //**************************************
    // rom shadow flag
    //**************************************

    always_ff @(posedge hwclk) begin
        if (!reset_n) begin
            rom_shadow <= 1'b1;                  // boot from the on-chip rom
        end else if (cycle_start && hit_rom_off) begin
            rom_shadow <= 1'b0;                  // one-way, sram from now on
        end
    end

    //**************************************
    // gpio output latch
    //**************************************

    // track the write while it lasts
    // cycle is already idle when cycle_end pulses
    always_ff @(posedge hwclk) begin
        if (!reset_n) begin
            wr_f1_pend <= 1'b0;
        end else if (cycle_end) begin
            wr_f1_pend <= 1'b0;
        end else if (hit_gpio_out) begin
            wr_f1_pend <= 1'b1;
        end
    end

    // data follows the bus during the strobe
    always_ff @(posedge hwclk) begin
        if (hit_gpio_out) begin
            wr_data <= data_s;
        end
    end

    // capture at the end of the write, like the trailing edge of /wr
    always_ff @(posedge hwclk) begin
        if (!reset_n) begin
            gpio_out <= GPIO_RESET;              // sd deselected, sck and mosi low
        end else if (cycle_end && wr_f1_pend) begin
            gpio_out <= wr_data;
        end
    end

endmodule

//--- rtl/z180_glue_pkg.sv
//**************************************
// shared types and constants for the Z180 glue
// I/O ports decode on the low address byte only
//**************************************

package z180_glue_pkg;

    //**************************************
    // bus types
    //**************************************

    typedef logic [19:0] addr_t;     // cpu physical address (1 MiB)
    typedef logic [7:0]  byte_t;     // one data byte
    typedef logic [7:0]  io_port_t;  // i/o port number from a[7:0]

    // classified bus cycle as seen in the hwclk domain
    typedef enum logic [2:0] {
        CYC_IDLE,       // no strobe active or cycle not decoded
        CYC_MEM_RD,     // mreq + rd
        CYC_MEM_WR,     // mreq + wr
        CYC_IO_RD,      // iorq + rd, m1 high
        CYC_IO_WR       // iorq + wr, m1 high
    } bus_cycle_e;

    //**************************************
    // port map
    //**************************************

    localparam io_port_t PORT_GPIO_IN  = 8'hf0;  // sd miso / card detect
    localparam io_port_t PORT_GPIO_OUT = 8'hf1;  // sd mosi, sck, select latch
    localparam io_port_t PORT_ROM_OFF  = 8'hfe;  // read to drop the boot rom

    // gpio latch after reset
    // bit 2 = sd select (high, card deselected), bit 1 = sck, bit 0 = mosi
    localparam byte_t GPIO_RESET = 8'h04;

    //**************************************
    // synchronizer
    //**************************************

    // flops between the cpu pins and the cycle fsm
    // pin change shows on cycle SYNC_STAGES+1 clocks later
    localparam int SYNC_STAGES = 2;

endpackage

//--- rtl/z180_glue_top.sv
//**************************************
// Z8S180 glue: decode, shadow boot rom, sd gpio, sram enables
// controls follow a strobe edge by 4 hwclk, no wait states
// d_in / d_out / d_oe form the tri-state bus at the board top
//**************************************
`timescale 1ns/100ps

module z180_glue_top #(
    parameter int                   ROM_ADDR_BITS = 12,           // 4 KiB boot rom
    parameter z180_glue_pkg::addr_t RAM_START     = 20'h0_1000
) (
    input  logic                 hwclk,
    input  logic                 reset_n,
    input  z180_glue_pkg::addr_t a,
    input  z180_glue_pkg::byte_t d_in,
    input  logic                 rd_n,
    input  logic                 wr_n,
    input  logic                 mreq_n,
    input  logic                 iorq_n,
    input  logic                 m1_n,
    input  logic                 sd_miso,
    input  logic                 sd_det,
    output z180_glue_pkg::byte_t d_out,
    output logic                 d_oe,
    output logic                 ce_n,
    output logic                 oe_n,
    output logic                 we_n,
    output logic                 sd_mosi,
    output logic                 sd_clk,
    output logic                 sd_ssel_n
);
    import z180_glue_pkg::*;

    bus_cycle_e cycle;
    addr_t      addr_s;
    byte_t      data_s;
    logic       cycle_start;
    logic       cycle_end;
    logic       rom_shadow;
    logic       gpio_rd_sel;
    byte_t      gpio_out;

    //**************************************
    // cpu bus front end
    //**************************************

    bus_cycle_sync u_bus_cycle_sync (
        .hwclk       (hwclk),
        .reset_n     (reset_n),
        .a           (a),
        .d_in        (d_in),
        .rd_n        (rd_n),
        .wr_n        (wr_n),
        .mreq_n      (mreq_n),
        .iorq_n      (iorq_n),
        .m1_n        (m1_n),
        .cycle       (cycle),
        .addr_s      (addr_s),
        .data_s      (data_s),
        .cycle_start (cycle_start),
        .cycle_end   (cycle_end)
    );

    io_port_regs u_io_port_regs (
        .hwclk       (hwclk),
        .reset_n     (reset_n),
        .cycle       (cycle),
        .addr_s      (addr_s),
        .data_s      (data_s),
        .cycle_start (cycle_start),
        .cycle_end   (cycle_end),
        .rom_shadow  (rom_shadow),
        .gpio_rd_sel (gpio_rd_sel),
        .gpio_out    (gpio_out)
    );

    data_bus_driver #(
        .ROM_ADDR_BITS (ROM_ADDR_BITS),
        .RAM_START     (RAM_START)
    ) u_data_bus_driver (
        .hwclk       (hwclk),
        .reset_n     (reset_n),
        .cycle       (cycle),
        .addr_s      (addr_s),
        .rom_shadow  (rom_shadow),
        .gpio_rd_sel (gpio_rd_sel),
        .sd_miso     (sd_miso),
        .sd_det      (sd_det),
        .d_out       (d_out),
        .d_oe        (d_oe),
        .ce_n        (ce_n),
        .oe_n        (oe_n),
        .we_n        (we_n)
    );

    // gpio latch bits to the sd card
    assign sd_mosi   = gpio_out[0];
    assign sd_clk    = gpio_out[1];
    assign sd_ssel_n = gpio_out[2];

endmodule

//--- verif/z180_glue_asserts.sv
//**************************************
// bus drive and sram enable rules, bound into z180_glue_top
// enables and d_oe are registered, one clock behind cycle
//**************************************
`timescale 1ns/100ps

module z180_glue_asserts (
    input logic                      hwclk,
    input logic                      reset_n,
    input z180_glue_pkg::bus_cycle_e cycle,
    input logic                      d_oe,
    input logic                      ce_n,
    input logic                      oe_n,
    input logic                      we_n
);
    import z180_glue_pkg::*;

    int n_oe_we  = 0;   // oe_n and we_n low together
    int n_oe_ce  = 0;   // glue and sram both on the bus
    int n_oe_cyc = 0;   // drive outside a read

    // sram never read and written at once
    a_oe_we: assert property (@(posedge hwclk) disable iff (!reset_n) oe_n || we_n)
        else begin
            $error("oe_n and we_n both low");
            n_oe_we++;
        end

    a_oe_ce: assert property (@(posedge hwclk) disable iff (!reset_n) !(d_oe && !ce_n))
        else begin
            $error("d_oe high while sram ce_n is low");
            n_oe_ce++;
        end

    // d_oe is registered, so it trails cycle by one clock
    a_oe_rd: assert property (@(posedge hwclk) disable iff (!reset_n)
        d_oe |-> ($past(cycle) == CYC_MEM_RD || $past(cycle) == CYC_IO_RD))
        else begin
            $error("d_oe high outside a read cycle");
            n_oe_cyc++;
        end

endmodule

bind z180_glue_top z180_glue_asserts u_glue_asserts (
    .hwclk   (hwclk),
    .reset_n (reset_n),
    .cycle   (cycle),
    .d_oe    (d_oe),
    .ce_n    (ce_n),
    .oe_n    (oe_n),
    .we_n    (we_n)
);

//--- verif/z180_bus_model.svh
//**************************************
// cpu bus cycles for the glue testbench, included in its module body
// tasks start and end 1 ns after a rising hwclk edge
// strobe held 8 clocks, sampled 6 in, then 4 idle clocks
//**************************************
`ifndef Z180_BUS_MODEL_SVH
`define Z180_BUS_MODEL_SVH

// step n edges, land on the drive point
task automatic wait_cycles(input int n);
    repeat (n) @(posedge hwclk);
    #1;
endtask

// one strobed cycle, flags are active high
task automatic run_cycle(input addr_t addr, input byte_t data, input logic rd,
                         input logic wr, input logic mreq, input logic iorq, input logic m1);
    a      = addr;
    d_in   = data;
    rd_n   = !rd;
    wr_n   = !wr;
    mreq_n = !mreq;
    iorq_n = !iorq;
    m1_n   = !m1;
    wait_cycles(6);                 // outputs settled 2 clocks ago
    smp_d    = d_out;
    smp_oe   = d_oe;
    smp_ce_n = ce_n;
    smp_oe_n = oe_n;
    smp_we_n = we_n;
    wait_cycles(2);
    rd_n   = 1'b1;                  // address and data stay put on release
    wr_n   = 1'b1;
    mreq_n = 1'b1;
    iorq_n = 1'b1;
    m1_n   = 1'b1;
    wait_cycles(4);                 // enables back to idle, gpio loaded
endtask

task automatic mem_read(input addr_t addr);
    run_cycle(addr, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
endtask

task automatic mem_write(input addr_t addr, input byte_t data);
    run_cycle(addr, data, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
endtask

task automatic io_read(input addr_t addr);
    run_cycle(addr, 8'h00, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
endtask

task automatic io_write(input addr_t addr, input byte_t data);
    run_cycle(addr, data, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
endtask

`endif

//--- verif/z180_glue_tb.sv
//**************************************
// testbench for z180_glue_top, bus cycles from z180_bus_model.svh
// expected rom bytes come from rtl/boot_rom.hex, run from the project root
//**************************************
`timescale 1ns/100ps

module z180_glue_tb;
    import z180_glue_pkg::*;

    localparam int    ROM_ADDR_BITS = 12;
    localparam addr_t RAM_START     = 20'h0_1000;
    localparam int    SEED          = 32'h2abe_00b5;

    // bus cycles per test section
    localparam int N_ROM_RD = 16;
    localparam int N_RAM_RD = 8;
    localparam int N_F1_WR  = 8;
    localparam int N_MEM_WR = 4;
    localparam int N_F0_RD  = 8;
    localparam int N_BUS    = N_ROM_RD + N_RAM_RD + N_F1_WR + N_MEM_WR + N_F0_RD + 1 + 4 + 2 + 2;
    localparam int TIMEOUT_CYCLES = N_BUS * 12 + 100;   // 12 clocks per bus cycle

    logic  hwclk, reset_n;
    addr_t a;
    byte_t d_in, d_out;
    logic  rd_n, wr_n, mreq_n, iorq_n, m1_n;
    logic  sd_miso, sd_det;
    logic  d_oe, ce_n, oe_n, we_n;
    logic  sd_mosi, sd_clk, sd_ssel_n;

    byte_t smp_d;                                // outputs at the sample point
    logic  smp_oe, smp_ce_n, smp_oe_n, smp_we_n;

    byte_t rom_img [2**ROM_ADDR_BITS];           // testbench copy of the boot image
    logic  shadow_ref;                           // model of the shadow flag
    byte_t gpio_ref;                             // model of the gpio latch
    int    cycle_count = 0;

    `include "z180_bus_model.svh"

    //**************************************
    // reference model
    //**************************************

    // is the glue itself expected to drive this read
    function automatic logic expect_drive(input bit is_io, input addr_t addr);
        if (is_io) return addr[7:0] == PORT_GPIO_IN;
        return shadow_ref && (addr < RAM_START);
    endfunction

    function automatic byte_t expect_read(input bit is_io, input addr_t addr,
                                          input logic miso, input logic det);
        if (!is_io && shadow_ref && addr < RAM_START)
            return rom_img[addr[ROM_ADDR_BITS-1:0]];
        if (is_io && addr[7:0] == PORT_GPIO_IN)
            return {miso, det, 6'b000000};
        return 8'h00;                            // bus left to the sram
    endfunction

    // upper address byte is whatever b held, decode must ignore it
    function automatic addr_t io_addr(input io_port_t port);
        int unsigned rnd;
        rnd = $urandom;
        return {4'h0, rnd[7:0], port};
    endfunction

    function automatic addr_t rom_addr();
        int unsigned rnd;
        rnd = $urandom;
        if (rnd[31]) rnd = rnd % 32;             // half the time inside the image
        else rnd = rnd % 32'(RAM_START);
        return rnd[19:0];
    endfunction

    function automatic addr_t ram_addr();
        int unsigned rnd;
        rnd = 32'(RAM_START) + ($urandom % (32'h10_0000 - 32'(RAM_START)));
        return rnd[19:0];
    endfunction

    function automatic byte_t gpio_pins();
        return {5'b00000, sd_ssel_n, sd_clk, sd_mosi};
    endfunction

    // failures counted by the bound checker so far
    function automatic int assert_fails();
        return u_z180_glue_top.u_glue_asserts.n_oe_we
             + u_z180_glue_top.u_glue_asserts.n_oe_ce
             + u_z180_glue_top.u_glue_asserts.n_oe_cyc;
    endfunction

    //**************************************
    // compare tasks
    //**************************************

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            abort_run();
        end
    endtask

    task automatic check_gpio(input byte_t got, input byte_t exp);
        byte_t exp_pins;
        exp_pins = exp & 8'h07;                  // bits 0..2 reach the sd pins
        if (got !== exp_pins) begin
            $display("[FAIL] sd_ssel_n/sd_clk/sd_mosi got 0x%02h expected 0x%02h at %0t",
                     got, exp_pins, $time);
            abort_run();
        end
    endtask

    task automatic check_released();
        check_bit("d_oe", d_oe, 1'b0);
        check_bit("ce_n", ce_n, 1'b1);
        check_bit("oe_n", oe_n, 1'b1);
        check_bit("we_n", we_n, 1'b1);
    endtask

    task automatic check_read_cycle(input bit is_io, input addr_t addr);
        logic exp_oe;
        exp_oe = expect_drive(is_io, addr);
        check_bit("d_oe", smp_oe, exp_oe);
        if (exp_oe) check_byte("d_out", smp_d, expect_read(is_io, addr, sd_miso, sd_det));
        check_bit("ce_n", smp_ce_n, is_io || exp_oe);   // sram only when nobody else serves
        check_bit("oe_n", smp_oe_n, is_io);
        check_bit("we_n", smp_we_n, 1'b1);
        if (is_io && addr[7:0] == PORT_ROM_OFF) shadow_ref = 1'b0;
        check_released();
    endtask

    task automatic check_write_cycle(input bit is_io, input addr_t addr, input byte_t data);
        check_bit("d_oe", smp_oe, 1'b0);
        check_bit("ce_n", smp_ce_n, is_io);
        check_bit("oe_n", smp_oe_n, 1'b1);
        check_bit("we_n", smp_we_n, is_io);
        if (is_io && addr[7:0] == PORT_GPIO_OUT) gpio_ref = data;
        check_released();
        check_gpio(gpio_pins(), gpio_ref);       // latch loaded 4 clocks after release
    endtask

    task automatic apply_reset();
        reset_n = 1'b0;
        wait_cycles(3);
        reset_n = 1'b1;
        shadow_ref = 1'b1;
        gpio_ref   = GPIO_RESET;
    endtask

    //**************************************
    // dut, clock, timeout
    //**************************************

    z180_glue_top #(
        .ROM_ADDR_BITS (ROM_ADDR_BITS),
        .RAM_START     (RAM_START)
    ) u_z180_glue_top (
        .hwclk (hwclk), .reset_n (reset_n), .a (a), .d_in (d_in),
        .rd_n (rd_n), .wr_n (wr_n), .mreq_n (mreq_n), .iorq_n (iorq_n), .m1_n (m1_n),
        .sd_miso (sd_miso), .sd_det (sd_det), .d_out (d_out), .d_oe (d_oe),
        .ce_n (ce_n), .oe_n (oe_n), .we_n (we_n),
        .sd_mosi (sd_mosi), .sd_clk (sd_clk), .sd_ssel_n (sd_ssel_n)
    );

    initial begin
        hwclk = 1'b0;
        forever #2 hwclk = ~hwclk;               // 4 ns period
    end

    always @(posedge hwclk) begin
        cycle_count <= cycle_count + 1;
        if (assert_fails() != 0) begin
            $display("a bound assertion on the bus drive or the sram enables failed");
            abort_run();
        end else if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d clocks, the test sequence never finished", cycle_count);
            abort_run();
        end
    end

    //**************************************
    // test sequence
    //**************************************

    initial begin
        addr_t addr;
        byte_t data;
        int unsigned rnd;
        int   n_assert;
        void'($urandom(SEED));
        a = '0;
        d_in = '0;
        rd_n = 1'b1;
        wr_n = 1'b1;
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        m1_n = 1'b1;
        sd_miso = 1'b0;
        sd_det = 1'b0;
        for (int i = 0; i < 2**ROM_ADDR_BITS; i++) rom_img[i] = 8'hff;   // erased rom
        $readmemh("rtl/boot_rom.hex", rom_img);
        apply_reset();

        check_released();                        // idle bus after reset
        check_gpio(gpio_pins(), GPIO_RESET);

        repeat (N_ROM_RD) begin                  // shadow rom reads
            addr = rom_addr();
            mem_read(addr);
            check_read_cycle(1'b0, addr);
        end
        repeat (N_RAM_RD) begin
            addr = ram_addr();
            mem_read(addr);
            check_read_cycle(1'b0, addr);
        end

        repeat (N_F1_WR) begin                   // gpio latch and sram writes
            rnd = $urandom;
            addr = io_addr(PORT_GPIO_OUT);
            io_write(addr, rnd[7:0]);
            check_write_cycle(1'b1, addr, rnd[7:0]);
        end
        repeat (N_MEM_WR) begin
            rnd = $urandom;
            addr = rnd[31] ? rom_addr() : ram_addr();
            mem_write(addr, rnd[7:0]);
            check_write_cycle(1'b0, addr, rnd[7:0]);
        end

        repeat (N_F0_RD) begin                   // sd inputs on port f0
            rnd = $urandom;
            sd_miso = rnd[0];
            sd_det = rnd[1];
            addr = io_addr(PORT_GPIO_IN);
            io_read(addr);
            check_read_cycle(1'b1, addr);
        end

        addr = io_addr(PORT_ROM_OFF);            // rom off, low memory goes to sram
        io_read(addr);
        check_read_cycle(1'b1, addr);
        repeat (4) begin
            addr = rom_addr();
            mem_read(addr);
            check_read_cycle(1'b0, addr);
        end
        apply_reset();
        check_gpio(gpio_pins(), GPIO_RESET);
        repeat (2) begin                         // shadow back after reset
            addr = rom_addr();
            mem_read(addr);
            check_read_cycle(1'b0, addr);
        end

        // interrupt acknowledge style cycle on f0, m1 low
        sd_miso = 1'b1;
        sd_det = 1'b1;
        run_cycle(io_addr(PORT_GPIO_IN), 8'h00, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
        check_bit("d_oe", smp_oe, 1'b0);
        check_bit("ce_n", smp_ce_n, 1'b1);
        check_bit("oe_n", smp_oe_n, 1'b1);
        check_released();
        check_gpio(gpio_pins(), gpio_ref);
        rnd = $urandom;
        data = rnd[7:0];
        data[2:0] = ~gpio_ref[2:0];              // every sd pin has to toggle
        addr = io_addr(PORT_GPIO_OUT);
        io_write(addr, data);
        check_write_cycle(1'b1, addr, data);

        n_assert = assert_fails();
        if (n_assert != 0) begin
            $display("bound assertions failed %0d times", n_assert);
            abort_run();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

//--- z180_glue_top.f
+incdir+verif
rtl/z180_glue_pkg.sv
rtl/bus_cycle_sync.sv
rtl/io_port_regs.sv
rtl/boot_rom.sv
rtl/data_bus_driver.sv
rtl/z180_glue_top.sv
verif/z180_glue_asserts.sv
verif/z180_glue_tb.sv
